//--- common/rr_pkg.sv
package rr_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths of the register access channels
  //////////////////////////////////////////////////////////////////////

  // Register address width on sda and ocl
  localparam int ADDR_W = 16;
  // Write data width on sda and ocl
  localparam int DATA_W = 32;
  // Record sequence number wrapping modulo 256
  localparam int SEQ_W = 8;

  //////////////////////////////////////////////////////////////////////
  // Per-channel log buffer
  //////////////////////////////////////////////////////////////////////

  // Entries buffered in each recorder
  localparam int LOG_DEPTH = 2;
  // Read/write pointer width of at least one bit
  localparam int LOG_PTR_W = (LOG_DEPTH > 1) ? $clog2(LOG_DEPTH) : 1;
  // Occupancy counter has to hold LOG_DEPTH itself
  localparam int LOG_CNT_W = $clog2(LOG_DEPTH + 1);

  typedef logic [ADDR_W-1:0] rr_addr_t;
  typedef logic [DATA_W-1:0] rr_data_t;
  typedef logic [SEQ_W-1:0]  rr_seq_t;
  // Channel tag on the record stream
  typedef logic              rr_chan_t;

  // Channel tag values
  localparam rr_chan_t CHAN_SDA = 1'b0;
  localparam rr_chan_t CHAN_OCL = 1'b1;

endpackage

//--- common/rr_log_if.sv
interface rr_log_if;
  import rr_pkg::*;

  // One channel's log entries from recorder to merger
  // Four-phase handshake
  //   recorder raises req with addr/data stable
  //   merger raises ack once the entry is taken
  //   recorder drops req, then merger drops ack
  // No new req while ack is still high

  logic     req;
  logic     ack;
  rr_addr_t addr;
  rr_data_t data;

  // Producer side that owns the log buffer
  modport recorder (
    output req,
    output addr,
    output data,
    input  ack
  );

  // Consumer side that only acknowledges
  modport merger (
    input  req,
    input  addr,
    input  data,
    output ack
  );

endinterface

//--- recorder/rr_chan_recorder.sv
module rr_chan_recorder (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_record_en,
  // Shell side
  input  logic             i_req,
  input  rr_pkg::rr_addr_t i_addr,
  input  rr_pkg::rr_data_t i_data,
  output logic             o_ack,
  // CL side
  output logic             o_cl_req,
  output rr_pkg::rr_addr_t o_cl_addr,
  output rr_pkg::rr_data_t o_cl_data,
  input  logic             i_cl_ack,
  // Log entries toward the merger
  rr_log_if.recorder       log
);
  import rr_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FORWARD,
    ST_WAIT_DROP,
    ST_WAIT_RELEASE
  } state_t;

  state_t state_q;
  // Record enable as sampled at acceptance
  logic rec_q;

  // Log FIFO storage
  rr_addr_t mem_addr [LOG_DEPTH];
  rr_data_t mem_data [LOG_DEPTH];
  logic [LOG_PTR_W-1:0] wr_ptr_q;
  logic [LOG_PTR_W-1:0] rd_ptr_q;
  logic [LOG_CNT_W-1:0] count_q;
  logic log_req_q;

  logic fifo_full;
  logic accept;
  logic push;
  logic pop;

  //////////////////////////////////////////////////////////////////////
  // Transaction pass-through
  //////////////////////////////////////////////////////////////////////

  assign fifo_full = (count_q == LOG_CNT_W'(LOG_DEPTH));
  // A recorded transaction needs a slot reserved up front
  // Only the drain side runs meanwhile, so the slot stays free
  assign accept = i_req && (!i_record_en || !fifo_full);
  // Entry is written in the same cycle o_ack rises
  assign push = (state_q == ST_FORWARD) && i_cl_ack && rec_q;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q  <= ST_IDLE;
      rec_q    <= 1'b0;
      o_cl_req <= 1'b0;
      o_ack    <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            rec_q    <= i_record_en;
            o_cl_req <= 1'b1;
            state_q  <= ST_FORWARD;
          end
        end
        // Wait for the CL to acknowledge
        ST_FORWARD: begin
          if (i_cl_ack) begin
            o_ack   <= 1'b1;
            state_q <= ST_WAIT_DROP;
          end
        end
        // Pass the shell's dropped request on
        ST_WAIT_DROP: begin
          if (!i_req) begin
            o_cl_req <= 1'b0;
            state_q  <= ST_WAIT_RELEASE;
          end
        end
        // CL releases ack and the shell sees the end of the transaction
        ST_WAIT_RELEASE: begin
          if (!i_cl_ack) begin
            o_ack   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address and data held stable while o_cl_req is up
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && accept) begin
      o_cl_addr <= i_addr;
      o_cl_data <= i_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Log FIFO and drain handshake
  //////////////////////////////////////////////////////////////////////

  // Head entry leaves when the merger acknowledges
  assign pop = log_req_q && log.ack;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_addr[wr_ptr_q] <= o_cl_addr;
      mem_data[wr_ptr_q] <= o_cl_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      log_req_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LOG_PTR_W'(LOG_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LOG_PTR_W'(LOG_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Raise only once the previous ack has gone low
      if (!log_req_q && !log.ack && (count_q != '0)) begin
        log_req_q <= 1'b1;
      end else if (pop) begin
        log_req_q <= 1'b0;
      end
    end
  end

  // Head of FIFO is the entry on offer
  assign log.req  = log_req_q;
  assign log.addr = mem_addr[rd_ptr_q];
  assign log.data = mem_data[rd_ptr_q];

endmodule

//--- verilog/rr_log_merger.sv
module rr_log_merger (
  input  logic             clk,
  input  logic             i_rst_n,
  // Channel logs from the recorders
  rr_log_if.merger         sda_log,
  rr_log_if.merger         ocl_log,
  // Stamped record stream
  output logic             o_log_req,
  output rr_pkg::rr_chan_t o_log_chan,
  output rr_pkg::rr_seq_t  o_log_seq,
  output rr_pkg::rr_addr_t o_log_addr,
  output rr_pkg::rr_data_t o_log_data,
  input  logic             i_log_ack
);
  import rr_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_TAKE,
    ST_PRESENT,
    ST_RELEASE
  } state_t;

  state_t state_q;
  // Granted channel and thus the one served last
  rr_chan_t gnt_q;
  rr_chan_t nxt_gnt;
  // Ack toward the granted recorder
  logic take_ack_q;
  rr_seq_t seq_q;

  logic any_req;
  logic sel_req;

  //////////////////////////////////////////////////////////////////////
  // Round-robin arbitration
  //////////////////////////////////////////////////////////////////////

  assign any_req = sda_log.req || ocl_log.req;

  // With both pending take the one not served last
  always_comb begin
    if (sda_log.req && ocl_log.req) begin
      nxt_gnt = ~gnt_q;
    end else if (ocl_log.req) begin
      nxt_gnt = CHAN_OCL;
    end else begin
      nxt_gnt = CHAN_SDA;
    end
  end

  // Request of the channel being taken
  assign sel_req = (gnt_q == CHAN_OCL) ? ocl_log.req : sda_log.req;

  // Steer the ack to the granted channel only
  assign sda_log.ack = take_ack_q && (gnt_q == CHAN_SDA);
  assign ocl_log.ack = take_ack_q && (gnt_q == CHAN_OCL);

  assign o_log_chan = gnt_q;

  //////////////////////////////////////////////////////////////////////
  // Take, present and release sequence
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q    <= ST_IDLE;
      // sda goes first after reset
      gnt_q      <= CHAN_OCL;
      take_ack_q <= 1'b0;
      o_log_req  <= 1'b0;
      seq_q      <= '0;
    end else begin
      case (state_q)
        // All channel acks are low here
        ST_IDLE: begin
          if (any_req) begin
            gnt_q      <= nxt_gnt;
            take_ack_q <= 1'b1;
            state_q    <= ST_TAKE;
          end
        end
        // Wait for the recorder to let go of the registered entry
        ST_TAKE: begin
          if (!sel_req) begin
            take_ack_q <= 1'b0;
            o_log_req  <= 1'b1;
            state_q    <= ST_PRESENT;
          end
        end
        ST_PRESENT: begin
          if (i_log_ack) begin
            o_log_req <= 1'b0;
            state_q   <= ST_RELEASE;
          end
        end
        // Entry complete once the sink drops ack
        ST_RELEASE: begin
          if (!i_log_ack) begin
            seq_q   <= seq_q + 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Output register loaded together with the grant
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && any_req) begin
      o_log_addr <= (nxt_gnt == CHAN_OCL) ? ocl_log.addr : sda_log.addr;
      o_log_data <= (nxt_gnt == CHAN_OCL) ? ocl_log.data : sda_log.data;
      o_log_seq  <= seq_q;
    end
  end

endmodule

//--- verilog/rr_record_top.sv
module rr_record_top (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_record_en,
  // sda, shell side
  input  logic             i_sda_req,
  input  rr_pkg::rr_addr_t i_sda_addr,
  input  rr_pkg::rr_data_t i_sda_data,
  output logic             o_sda_ack,
  // ocl, shell side
  input  logic             i_ocl_req,
  input  rr_pkg::rr_addr_t i_ocl_addr,
  input  rr_pkg::rr_data_t i_ocl_data,
  output logic             o_ocl_ack,
  // sda, CL side
  output logic             o_cl_sda_req,
  output rr_pkg::rr_addr_t o_cl_sda_addr,
  output rr_pkg::rr_data_t o_cl_sda_data,
  input  logic             i_cl_sda_ack,
  // ocl, CL side
  output logic             o_cl_ocl_req,
  output rr_pkg::rr_addr_t o_cl_ocl_addr,
  output rr_pkg::rr_data_t o_cl_ocl_data,
  input  logic             i_cl_ocl_ack,
  // Record stream
  output logic             o_log_req,
  output rr_pkg::rr_chan_t o_log_chan,
  output rr_pkg::rr_seq_t  o_log_seq,
  output rr_pkg::rr_addr_t o_log_addr,
  output rr_pkg::rr_data_t o_log_data,
  input  logic             i_log_ack
);

  //////////////////////////////////////////////////////////////////////
  // Channel recorders
  //////////////////////////////////////////////////////////////////////

  rr_log_if sda_log_if ();
  rr_log_if ocl_log_if ();

  rr_chan_recorder u_sda_rec (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_record_en (i_record_en),
    .i_req       (i_sda_req),
    .i_addr      (i_sda_addr),
    .i_data      (i_sda_data),
    .o_ack       (o_sda_ack),
    .o_cl_req    (o_cl_sda_req),
    .o_cl_addr   (o_cl_sda_addr),
    .o_cl_data   (o_cl_sda_data),
    .i_cl_ack    (i_cl_sda_ack),
    .log         (sda_log_if.recorder)
  );

  rr_chan_recorder u_ocl_rec (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_record_en (i_record_en),
    .i_req       (i_ocl_req),
    .i_addr      (i_ocl_addr),
    .i_data      (i_ocl_data),
    .o_ack       (o_ocl_ack),
    .o_cl_req    (o_cl_ocl_req),
    .o_cl_addr   (o_cl_ocl_addr),
    .o_cl_data   (o_cl_ocl_data),
    .i_cl_ack    (i_cl_ocl_ack),
    .log         (ocl_log_if.recorder)
  );

  //////////////////////////////////////////////////////////////////////
  // Merge into one record stream
  //////////////////////////////////////////////////////////////////////

  rr_log_merger u_merger (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .sda_log    (sda_log_if.merger),
    .ocl_log    (ocl_log_if.merger),
    .o_log_req  (o_log_req),
    .o_log_chan (o_log_chan),
    .o_log_seq  (o_log_seq),
    .o_log_addr (o_log_addr),
    .o_log_data (o_log_data),
    .i_log_ack  (i_log_ack)
  );

endmodule

//--- verif/tb_rr_record.sv
module tb_rr_record;
  import rr_pkg::*;

  localparam int N_ROWS = 10;
  // One entry parked in the merger plus a full recorder FIFO
  localparam int STALL_AFTER = 1 + LOG_DEPTH;
  localparam int N_BP = STALL_AFTER + 1;
  localparam int LIMIT_CYCLES = (N_ROWS + N_BP) * 40 + 200;

  typedef struct packed {
    rr_chan_t chan;
    rr_addr_t addr;
    rr_data_t data;
    logic     rec;
  } row_t;

  typedef struct packed {
    rr_addr_t addr;
    rr_data_t data;
  } entry_t;

  logic     clk;
  logic     rst_n;
  logic     record_en;
  logic     sda_req;
  rr_addr_t sda_addr;
  rr_data_t sda_data;
  logic     sda_ack;
  logic     ocl_req;
  rr_addr_t ocl_addr;
  rr_data_t ocl_data;
  logic     ocl_ack;
  logic     cl_sda_req;
  rr_addr_t cl_sda_addr;
  rr_data_t cl_sda_data;
  logic     cl_sda_ack;
  logic     cl_ocl_req;
  rr_addr_t cl_ocl_addr;
  rr_data_t cl_ocl_data;
  logic     cl_ocl_ack;
  logic     log_req;
  rr_chan_t log_chan;
  rr_seq_t  log_seq;
  rr_addr_t log_addr;
  rr_data_t log_data;
  logic     log_ack;

  row_t        rows [N_ROWS];
  entry_t      exp_sda_q [$];
  entry_t      exp_ocl_q [$];
  // Row currently on each channel indexed by the channel tag
  rr_addr_t    cur_addr [2];
  rr_data_t    cur_data [2];
  logic        cl_acked [2];
  int          done_cnt [2];
  int          n_recorded;
  int          recv_cnt;
  int          n_errors;
  int          n_pass;
  int          n_fail;
  logic        hold_sink;
  logic [31:0] lfsr_q = 32'h7b44;

  rr_record_top dut0 (
    .clk           (clk),
    .i_rst_n       (rst_n),
    .i_record_en   (record_en),
    .i_sda_req     (sda_req),
    .i_sda_addr    (sda_addr),
    .i_sda_data    (sda_data),
    .o_sda_ack     (sda_ack),
    .i_ocl_req     (ocl_req),
    .i_ocl_addr    (ocl_addr),
    .i_ocl_data    (ocl_data),
    .o_ocl_ack     (ocl_ack),
    .o_cl_sda_req  (cl_sda_req),
    .o_cl_sda_addr (cl_sda_addr),
    .o_cl_sda_data (cl_sda_data),
    .i_cl_sda_ack  (cl_sda_ack),
    .o_cl_ocl_req  (cl_ocl_req),
    .o_cl_ocl_addr (cl_ocl_addr),
    .o_cl_ocl_data (cl_ocl_data),
    .i_cl_ocl_ack  (cl_ocl_ack),
    .o_log_req     (log_req),
    .o_log_chan    (log_chan),
    .o_log_seq     (log_seq),
    .o_log_addr    (log_addr),
    .o_log_data    (log_data),
    .i_log_ack     (log_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], next_rand_bit()};
    end
    return v;
  endfunction

  // Ack delay of 0 to 7 cycles
  function automatic int rand_delay();
    return int'(rand_bits(3));
  endfunction

  // Sample and drive one time unit past the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    n_errors++;
    $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic report_fail(input string msg);
    n_errors++;
    $display("failure at t=%0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name, input int err_mark);
    if (n_errors == err_mark) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: %0d errors", name, n_errors - err_mark);
    end
  endtask

  function automatic void set_shell(input rr_chan_t ch, input logic req,
                                    input rr_addr_t a, input rr_data_t d);
    if (ch == CHAN_OCL) begin
      ocl_req  = req;
      ocl_addr = a;
      ocl_data = d;
    end else begin
      sda_req  = req;
      sda_addr = a;
      sda_data = d;
    end
  endfunction

  function automatic logic shell_ack(input rr_chan_t ch);
    return (ch == CHAN_OCL) ? ocl_ack : sda_ack;
  endfunction

  function automatic logic cl_req_of(input rr_chan_t ch);
    return (ch == CHAN_OCL) ? cl_ocl_req : cl_sda_req;
  endfunction

  function automatic void set_cl_ack(input rr_chan_t ch, input logic v);
    if (ch == CHAN_OCL) begin
      cl_ocl_ack = v;
    end else begin
      cl_sda_ack = v;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Shell driver and responders
  //////////////////////////////////////////////////////////////////////

  // One full four-phase shell transaction
  task automatic drive_shell(input rr_chan_t ch, input rr_addr_t a, input rr_data_t d,
                             input logic rec);
    entry_t e;
    e.addr = a;
    e.data = d;
    cur_addr[ch] = a;
    cur_data[ch] = d;
    cl_acked[ch] = 1'b0;
    if (rec) begin
      n_recorded++;
      if (ch == CHAN_OCL) begin
        exp_ocl_q.push_back(e);
      end else begin
        exp_sda_q.push_back(e);
      end
    end
    set_shell(ch, 1'b1, a, d);
    step();
    while (!shell_ack(ch)) step();
    if (!cl_acked[ch]) report_fail("shell ack came before the CL acknowledged");
    set_shell(ch, 1'b0, a, d);
    step();
    while (shell_ack(ch)) step();
    done_cnt[ch]++;
  endtask

  task automatic run_row(input int idx);
    drive_shell(rows[idx].chan, rows[idx].addr, rows[idx].data, rows[idx].rec);
  endtask

  // CL acks after a random delay and releases after another
  task automatic cl_respond(input rr_chan_t ch);
    int dly;
    forever begin
      step();
      if (cl_req_of(ch)) begin
        dly = rand_delay();
        repeat (dly) step();
        set_cl_ack(ch, 1'b1);
        cl_acked[ch] = 1'b1;
        step();
        while (cl_req_of(ch)) step();
        dly = rand_delay();
        repeat (dly) step();
        set_cl_ack(ch, 1'b0);
      end
    end
  endtask

  initial cl_respond(CHAN_SDA);
  initial cl_respond(CHAN_OCL);

  // Compare a record entry with the head of its channel queue
  task automatic check_entry();
    entry_t e;
    logic   found;
    found = 1'b0;
    if (log_seq !== rr_seq_t'(recv_cnt)) begin
      report_mismatch("o_log_seq", 32'(rr_seq_t'(recv_cnt)), 32'(log_seq));
    end
    if (log_chan === CHAN_OCL && exp_ocl_q.size() > 0) begin
      e = exp_ocl_q.pop_front();
      found = 1'b1;
    end else if (log_chan === CHAN_SDA && exp_sda_q.size() > 0) begin
      e = exp_sda_q.pop_front();
      found = 1'b1;
    end
    if (!found) begin
      report_fail("record entry arrived with no recorded row pending on its channel");
    end else begin
      if (log_addr !== e.addr) report_mismatch("o_log_addr", 32'(e.addr), 32'(log_addr));
      if (log_data !== e.data) report_mismatch("o_log_data", e.data, log_data);
    end
  endtask

  initial begin : log_sink
    int dly;
    forever begin
      step();
      if (log_req && !hold_sink) begin
        dly = rand_delay();
        repeat (dly) step();
        check_entry();
        log_ack = 1'b1;
        step();
        while (log_req) step();
        dly = rand_delay();
        repeat (dly) step();
        log_ack = 1'b0;
        recv_cnt++;
      end
    end
  end

  // Checks on the falling edge when every signal is settled
  initial begin : hygiene_monitor
    logic [2:0] req_now;
    logic [2:0] req_prev;
    logic [2:0] ack_prev;
    req_prev = '0;
    ack_prev = '0;
    forever begin
      @(negedge clk);
      req_now = {log_req, cl_ocl_req, cl_sda_req};
      // A rise is compared with the ack the DUT saw at that edge
      if (rst_n && |(req_now & ~req_prev & ack_prev)) begin
        report_fail("a request rose while its ack was still high");
      end
      if (cl_sda_req && cl_sda_addr !== cur_addr[0]) begin
        report_mismatch("o_cl_sda_addr", 32'(cur_addr[0]), 32'(cl_sda_addr));
      end
      if (cl_sda_req && cl_sda_data !== cur_data[0]) begin
        report_mismatch("o_cl_sda_data", cur_data[0], cl_sda_data);
      end
      if (cl_ocl_req && cl_ocl_addr !== cur_addr[1]) begin
        report_mismatch("o_cl_ocl_addr", 32'(cur_addr[1]), 32'(cl_ocl_addr));
      end
      if (cl_ocl_req && cl_ocl_data !== cur_data[1]) begin
        report_mismatch("o_cl_ocl_data", cur_data[1], cl_ocl_data);
      end
      req_prev = req_now;
      ack_prev = {log_ack, cl_ocl_ack, cl_sda_ack};
    end
  end

  initial begin : watchdog
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and test sequence
  //////////////////////////////////////////////////////////////////////

  // Columns are channel, addr, data, record enable
  task automatic fill_table();
    rows[0] = '{CHAN_SDA, 16'h0010, 32'h1111_0001, 1'b1};
    rows[1] = '{CHAN_OCL, 16'h0020, 32'h2222_0002, 1'b1};
    rows[2] = '{CHAN_SDA, 16'h0030, 32'h3333_0003, 1'b0};
    rows[3] = '{CHAN_OCL, 16'h0040, 32'h4444_0004, 1'b0};
    rows[4] = '{CHAN_SDA, 16'h0050, 32'h5555_0005, 1'b1};
    rows[5] = '{CHAN_SDA, 16'hfffc, 32'hdead_beef, 1'b1};
    rows[6] = '{CHAN_OCL, 16'h0104, 32'h0000_0000, 1'b1};
    rows[7] = '{CHAN_SDA, 16'h0200, 32'hffff_ffff, 1'b1};
    rows[8] = '{CHAN_OCL, 16'h0300, 32'ha5a5_5a5a, 1'b0};
    rows[9] = '{CHAN_OCL, 16'h0400, 32'h0bad_cafe, 1'b1};
  endtask

  task automatic wait_drained();
    while (recv_cnt < n_recorded) step();
  endtask

  initial begin : main_seq
    int i;
    int err_mark;
    int base;
    rst_n      = 1'b0;
    record_en  = 1'b0;
    hold_sink  = 1'b0;
    log_ack    = 1'b0;
    cl_sda_ack = 1'b0;
    cl_ocl_ack = 1'b0;
    set_shell(CHAN_SDA, 1'b0, '0, '0);
    set_shell(CHAN_OCL, 1'b0, '0, '0);
    cur_addr   = '{default: '0};
    cur_data   = '{default: '0};
    cl_acked   = '{default: 1'b0};
    done_cnt   = '{default: 0};
    n_recorded = 0;
    recv_cnt   = 0;
    n_errors   = 0;
    n_pass     = 0;
    n_fail     = 0;
    fill_table();
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;

    err_mark = n_errors;
    step();
    if ({sda_ack, ocl_ack, cl_sda_req, cl_ocl_req, log_req} !== 5'b0) begin
      report_fail("a req or ack output is not low after reset");
    end
    end_test("reset", err_mark);

    // Neighbouring rows on different channels with one enable run together
    err_mark = n_errors;
    i = 0;
    while (i < N_ROWS) begin
      record_en = rows[i].rec;
      if (i + 1 < N_ROWS && rows[i+1].chan != rows[i].chan && rows[i+1].rec == rows[i].rec) begin
        fork
          run_row(i);
          run_row(i + 1);
        join
        i += 2;
      end else begin
        run_row(i);
        i += 1;
      end
    end
    wait_drained();
    end_test("table", err_mark);

    // Sink holds off while sda fills merger and FIFO and then has to stall
    err_mark = n_errors;
    record_en = 1'b1;
    hold_sink = 1'b1;
    base = done_cnt[0];
    fork
      begin
        for (int k = 0; k < N_BP; k++) begin
          drive_shell(CHAN_SDA, rr_addr_t'(rand_bits(ADDR_W)), rand_bits(DATA_W), 1'b1);
        end
      end
      begin
        while (done_cnt[0] < base + STALL_AFTER) step();
        repeat (20) step();
        if (done_cnt[0] != base + STALL_AFTER) begin
          report_fail("sda transaction finished although the log buffer was full");
        end
        if (sda_ack || cl_sda_req) report_fail("sda did not stall under log back-pressure");
        hold_sink = 1'b0;
      end
    join
    wait_drained();
    end_test("back_pressure", err_mark);

    // Nothing left over and nothing extra
    err_mark = n_errors;
    repeat (20) step();
    if (exp_sda_q.size() != 0 || exp_ocl_q.size() != 0) begin
      report_fail("recorded rows never reached the record stream");
    end
    if (recv_cnt != n_recorded) report_mismatch("record entry count", n_recorded, recv_cnt);
    if (log_req) report_fail("record stream still requesting after the last entry");
    end_test("drain", err_mark);

    $display("tests: %0d passed, %0d failed, errors: %0d", n_pass, n_fail, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- fpgarr_lite.f
common/rr_pkg.sv
common/rr_log_if.sv
recorder/rr_chan_recorder.sv
verilog/rr_log_merger.sv
verilog/rr_record_top.sv
verif/tb_rr_record.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fpgarr_lite testbench with Verilator
# The run counts as passed only if the pass line shows up in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_rr_record \
  -Mdir "$OBJ" -o Vtb_rr_record -f fpgarr_lite.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/Vtb_rr_record" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi
